// ==== include/group_noc_params.svh ====
// ==========================================================
// Group NoC adapter sizing
// Mesh, tile, address, data and router buffer dimensions
// ==========================================================

`ifndef GROUP_NOC_PARAMS_SVH
`define GROUP_NOC_PARAMS_SVH

// Mesh coordinate width, 4x4 groups
`define GROUP_COORD_W 2

// Tiles inside one group
`define NUM_TILES     4
`define TILE_ID_W     2

// Group-local address, tile index sits in the top bits
`define ADDR_W        12
`define TILE_ADDR_W   10

`define DATA_W        32
`define BE_W          4

`define FIFO_DEPTH    2  // Entries per router input
`define NUM_DIRS      5  // Local plus four mesh ports

`endif

// ==== src/group_noc_pkg.sv ====
// ==========================================================
// Group NoC types
// Opcodes, router directions and request/flit structs
// ==========================================================

`include "group_noc_params.svh"

package group_noc_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Router port numbering, also the index of every port array
  typedef enum logic [2:0] {
    DIR_LOCAL = 3'd0,
    DIR_NORTH = 3'd1,
    DIR_EAST  = 3'd2,
    DIR_SOUTH = 3'd3,
    DIR_WEST  = 3'd4
  } dir_e;

  typedef struct packed {
    logic [`GROUP_COORD_W-1:0] x;
    logic [`GROUP_COORD_W-1:0] y;
  } group_xy_t;

  // Remote request as issued by a tile
  typedef struct packed {
    op_e                op;
    logic [`BE_W-1:0]   be;
    logic [`ADDR_W-1:0] addr;   // Group-local
    logic [`DATA_W-1:0] data;
    group_xy_t          dst_group;
  } tile_req_t;

  typedef struct packed {
    group_xy_t             src_group;  // Header
    logic [`TILE_ID_W-1:0] src_tile;
    group_xy_t             dst_group;
    logic [`ADDR_W-1:0]    addr;
    op_e                   op;         // Payload
    logic [`BE_W-1:0]      be;
    logic [`DATA_W-1:0]    data;
  } flit_t;

  // Request into a tile memory, group bits already stripped
  typedef struct packed {
    op_e                     op;
    logic [`BE_W-1:0]        be;
    logic [`TILE_ADDR_W-1:0] addr;
    logic [`DATA_W-1:0]      data;
    group_xy_t               src_group;
    logic [`TILE_ID_W-1:0]   src_tile;
  } slave_req_t;

  // Round-robin pick among n <= 8 requesters
  // Search starts right after last and wraps, last itself comes final
  function automatic logic [2:0] rr_pick(input logic [7:0] req, input logic [2:0] last,
                                         input int n);
    logic [2:0] pick;
    int         idx;
    pick = last;
    for (int k = 8; k > 0; k--) begin
      idx = (int'(last) + k) % n;
      if (k <= n && req[idx]) pick = 3'(idx);  // Nearest candidate wins
    end
    return pick;
  endfunction

endpackage

// ==== src/flit_fifo.sv ====
// ==========================================================
// Flit FIFO
// Small circular buffer with valid/ready on both sides
// ==========================================================

module flit_fifo #(
  parameter int unsigned DEPTH = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  group_noc_pkg::flit_t in_flit_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  output group_noc_pkg::flit_t out_flit_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  group_noc_pkg::flit_t mem_q [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     count_q;
  logic [CNT_W-1:0]     count_d;
  logic                 not_full_q;  // Registered ready, low through reset
  logic                 push;
  logic                 pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) return '0;
    return ptr + 1'b1;
  endfunction

  assign push        = in_valid_i & not_full_q;
  assign pop         = out_valid_o & out_ready_i;
  assign count_d     = count_q + CNT_W'(push) - CNT_W'(pop);
  assign in_ready_o  = not_full_q;
  assign out_valid_o = (count_q != '0);
  assign out_flit_o  = mem_q[rd_ptr_q];  // Oldest entry

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      not_full_q <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q    <= count_d;
      not_full_q <= (count_d != CNT_W'(DEPTH));
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_flit_i;
  end

endmodule

// ==== src/tcdm_flit_packer.sv ====
// ==========================================================
// TCDM flit packer
// Arbitrates tile requests and registers them as flits
// ==========================================================

`include "group_noc_params.svh"

module tcdm_flit_packer (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  group_noc_pkg::group_xy_t                  group_id_i,
  input  group_noc_pkg::tile_req_t [`NUM_TILES-1:0] tile_req_i,
  input  logic                     [`NUM_TILES-1:0] tile_valid_i,
  output logic                     [`NUM_TILES-1:0] tile_ready_o,
  output group_noc_pkg::flit_t                      flit_o,
  output logic                                      flit_valid_o,
  input  logic                                      flit_ready_i
);

  localparam int unsigned TW = `TILE_ID_W;

  logic [TW-1:0]        last_q;   // Previous winner
  logic [TW-1:0]        pick;
  logic                 en_q;     // Set one clock after reset
  logic                 valid_q;
  logic                 can_load;
  logic                 load;
  group_noc_pkg::flit_t flit_d;
  group_noc_pkg::flit_t flit_q;

  assign pick = TW'(group_noc_pkg::rr_pick(8'(tile_valid_i), 3'(last_q), `NUM_TILES));

  // Output register is empty or drains this cycle
  assign can_load = en_q & (~valid_q | flit_ready_i);
  assign load     = can_load & tile_valid_i[pick];

  always_comb begin
    tile_ready_o       = '0;
    tile_ready_o[pick] = can_load;  // Only the winner sees ready
  end

  assign flit_d = '{
    src_group: group_id_i,
    src_tile:  pick,
    dst_group: tile_req_i[pick].dst_group,
    addr:      tile_req_i[pick].addr,
    op:        tile_req_i[pick].op,
    be:        tile_req_i[pick].be,
    data:      tile_req_i[pick].data
  };

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q    <= 1'b0;
      valid_q <= 1'b0;
      last_q  <= '1;  // Tile 0 goes first
    end else begin
      en_q <= 1'b1;
      if (load) begin
        valid_q <= 1'b1;
        last_q  <= pick;
      end else if (flit_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) flit_q <= flit_d;
  end

  assign flit_o       = flit_q;
  assign flit_valid_o = valid_q;

endmodule

// ==== src/xy_router.sv ====
// ==========================================================
// XY router
// Five ports, buffered inputs, round-robin per output
// ==========================================================

`include "group_noc_params.svh"

module xy_router (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  group_noc_pkg::group_xy_t                group_id_i,
  input  group_noc_pkg::flit_t [`NUM_DIRS-1:0]    in_flit_i,
  input  logic                 [`NUM_DIRS-1:0]    in_valid_i,
  output logic                 [`NUM_DIRS-1:0]    in_ready_o,
  output group_noc_pkg::flit_t [`NUM_DIRS-1:0]    out_flit_o,
  output logic                 [`NUM_DIRS-1:0]    out_valid_o,
  input  logic                 [`NUM_DIRS-1:0]    out_ready_i
);

  localparam int unsigned ND = `NUM_DIRS;

  group_noc_pkg::flit_t [ND-1:0]         head_flit;
  logic                 [ND-1:0]         head_valid;
  logic                 [ND-1:0]         head_ready;
  group_noc_pkg::dir_e                   route [ND];
  logic                 [ND-1:0][ND-1:0] req;        // [output][input]
  logic                 [2:0]            pick [ND];
  logic                 [2:0]            last_q [ND];
  logic                 [ND-1:0]         hold_q;     // Output stalled last cycle
  logic                 [2:0]            held_q [ND];

  // Resolve x before y
  function automatic group_noc_pkg::dir_e xy_route(input group_noc_pkg::group_xy_t dst,
                                                   input group_noc_pkg::group_xy_t own);
    if (dst.x > own.x) return group_noc_pkg::DIR_EAST;
    if (dst.x < own.x) return group_noc_pkg::DIR_WEST;
    if (dst.y > own.y) return group_noc_pkg::DIR_NORTH;
    if (dst.y < own.y) return group_noc_pkg::DIR_SOUTH;
    return group_noc_pkg::DIR_LOCAL;
  endfunction

  for (genvar d = 0; d < ND; d++) begin : gen_in_port
    flit_fifo #(
      .DEPTH       (`FIFO_DEPTH  )
    ) i_in_fifo (
      .clk_i       (clk_i        ),
      .rst_n_i     (rst_n_i      ),
      .in_flit_i   (in_flit_i[d] ),
      .in_valid_i  (in_valid_i[d]),
      .in_ready_o  (in_ready_o[d]),
      .out_flit_o  (head_flit[d] ),
      .out_valid_o (head_valid[d]),
      .out_ready_i (head_ready[d])
    );

    assign route[d] = xy_route(head_flit[d].dst_group, group_id_i);
  end : gen_in_port

  // Request matrix from valid heads
  always_comb begin
    req = '0;
    for (int i = 0; i < ND; i++) begin
      if (head_valid[i]) req[route[i]][i] = 1'b1;
    end
  end

  for (genvar o = 0; o < ND; o++) begin : gen_out_port
    // A stalled output keeps its grant so the flit stays stable
    assign pick[o]        = hold_q[o] ? held_q[o]
                                      : group_noc_pkg::rr_pick(8'(req[o]), last_q[o], ND);
    assign out_valid_o[o] = |req[o];
    assign out_flit_o[o]  = head_flit[pick[o]];
  end : gen_out_port

  // A head pops once its output picks it and is ready
  always_comb begin
    for (int i = 0; i < ND; i++) begin
      head_ready[i] = out_ready_i[route[i]] && (pick[route[i]] == 3'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < ND; o++) begin
      held_q[o] <= pick[o];
      if (!rst_n_i) begin
        last_q[o] <= 3'(ND - 1);  // Local input first
        hold_q[o] <= 1'b0;
      end else begin
        hold_q[o] <= out_valid_o[o] && !out_ready_i[o];
        if (out_valid_o[o] && out_ready_i[o]) begin
          last_q[o] <= pick[o];
        end
      end
    end
  end

endmodule

// ==== src/tile_req_demux.sv ====
// ==========================================================
// Tile request demux
// Steers a delivered flit to its tile as a slave request
// ==========================================================

`include "group_noc_params.svh"

module tile_req_demux (
  input  group_noc_pkg::flit_t                       flit_i,
  input  logic                                       flit_valid_i,
  output logic                                       flit_ready_o,
  output group_noc_pkg::slave_req_t [`NUM_TILES-1:0] slave_req_o,
  output logic                      [`NUM_TILES-1:0] slave_valid_o,
  input  logic                      [`NUM_TILES-1:0] slave_ready_i
);

  localparam int unsigned TW = `TILE_ID_W;

  logic [TW-1:0]             tile_sel;
  group_noc_pkg::slave_req_t req;

  assign tile_sel = flit_i.addr[`TILE_ADDR_W +: TW];  // Address bits 11..10

  // Tile bits dropped, source kept for the way back
  assign req = '{
    op:        flit_i.op,
    be:        flit_i.be,
    addr:      flit_i.addr[`TILE_ADDR_W-1:0],
    data:      flit_i.data,
    src_group: flit_i.src_group,
    src_tile:  flit_i.src_tile
  };

  assign flit_ready_o = slave_ready_i[tile_sel];

  for (genvar t = 0; t < `NUM_TILES; t++) begin : gen_tile
    assign slave_req_o[t]   = req;
    assign slave_valid_o[t] = flit_valid_i && (tile_sel == TW'(t));
  end : gen_tile

endmodule

// ==== src/group_noc_top.sv ====
// ==========================================================
// Group NoC adapter
// Tile requests in, mesh flits through, slave requests out
// ==========================================================

`include "group_noc_params.svh"

module group_noc_top (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  group_noc_pkg::group_xy_t                             group_id_i,
  // Tile master side
  input  group_noc_pkg::tile_req_t  [`NUM_TILES-1:0]           tile_req_i,
  input  logic                      [`NUM_TILES-1:0]           tile_valid_i,
  output logic                      [`NUM_TILES-1:0]           tile_ready_o,
  // Tile slave side
  output group_noc_pkg::slave_req_t [`NUM_TILES-1:0]           slave_req_o,
  output logic                      [`NUM_TILES-1:0]           slave_valid_o,
  input  logic                      [`NUM_TILES-1:0]           slave_ready_i,
  // Mesh links, North up to West
  input  group_noc_pkg::flit_t
           [group_noc_pkg::DIR_WEST:group_noc_pkg::DIR_NORTH] mesh_flit_i,
  input  logic
           [group_noc_pkg::DIR_WEST:group_noc_pkg::DIR_NORTH] mesh_valid_i,
  output logic
           [group_noc_pkg::DIR_WEST:group_noc_pkg::DIR_NORTH] mesh_ready_o,
  output group_noc_pkg::flit_t
           [group_noc_pkg::DIR_WEST:group_noc_pkg::DIR_NORTH] mesh_flit_o,
  output logic
           [group_noc_pkg::DIR_WEST:group_noc_pkg::DIR_NORTH] mesh_valid_o,
  input  logic
           [group_noc_pkg::DIR_WEST:group_noc_pkg::DIR_NORTH] mesh_ready_i
);

  group_noc_pkg::flit_t                 pack_flit;
  logic                                 pack_valid;
  logic                                 pack_ready;
  group_noc_pkg::flit_t                 local_flit;
  logic                                 local_valid;
  logic                                 local_ready;
  group_noc_pkg::flit_t [`NUM_DIRS-1:0] rt_in_flit;
  logic                 [`NUM_DIRS-1:0] rt_in_valid;
  logic                 [`NUM_DIRS-1:0] rt_in_ready;
  group_noc_pkg::flit_t [`NUM_DIRS-1:0] rt_out_flit;
  logic                 [`NUM_DIRS-1:0] rt_out_valid;
  logic                 [`NUM_DIRS-1:0] rt_out_ready;

  tcdm_flit_packer i_packer (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .group_id_i   (group_id_i  ),
    .tile_req_i   (tile_req_i  ),
    .tile_valid_i (tile_valid_i),
    .tile_ready_o (tile_ready_o),
    .flit_o       (pack_flit   ),
    .flit_valid_o (pack_valid  ),
    .flit_ready_i (pack_ready  )
  );

  // Local sits at index 0, mesh ports above it
  assign rt_in_flit                = {mesh_flit_i, pack_flit};
  assign rt_in_valid               = {mesh_valid_i, pack_valid};
  assign {mesh_ready_o, pack_ready} = rt_in_ready;
  assign {mesh_flit_o, local_flit}  = rt_out_flit;
  assign {mesh_valid_o, local_valid} = rt_out_valid;
  assign rt_out_ready              = {mesh_ready_i, local_ready};

  xy_router i_router (
    .clk_i       (clk_i       ),
    .rst_n_i     (rst_n_i     ),
    .group_id_i  (group_id_i  ),
    .in_flit_i   (rt_in_flit  ),
    .in_valid_i  (rt_in_valid ),
    .in_ready_o  (rt_in_ready ),
    .out_flit_o  (rt_out_flit ),
    .out_valid_o (rt_out_valid),
    .out_ready_i (rt_out_ready)
  );

  tile_req_demux i_demux (
    .flit_i        (local_flit   ),
    .flit_valid_i  (local_valid  ),
    .flit_ready_o  (local_ready  ),
    .slave_req_o   (slave_req_o  ),
    .slave_valid_o (slave_valid_o),
    .slave_ready_i (slave_ready_i)
  );

endmodule

// ==== sim/tb_group_noc.sv ====
// ==========================================================
// Group NoC adapter testbench
// Table-driven requests checked against an XY routing model
// ==========================================================

`include "group_noc_params.svh"

module tb_group_noc;

  localparam int NUM_STIM  = 18;
  localparam int TIMEOUT   = 200;  // Cycles per wait
  localparam int STALL_CYC = 10;
  localparam int FLIT_W    = $bits(group_noc_pkg::flit_t);
  localparam group_noc_pkg::group_xy_t OWN = '{x: 2'd1, y: 2'd2};
  localparam group_noc_pkg::op_e RD = group_noc_pkg::OP_READ;
  localparam group_noc_pkg::op_e WR = group_noc_pkg::OP_WRITE;

  typedef struct packed {
    logic                     mesh;   // Source is a mesh input
    logic [2:0]               src;    // Tile index, or dir_e of the mesh port
    logic                     sync;   // Issued together with the next entry
    group_noc_pkg::group_xy_t dst;
    logic [`ADDR_W-1:0]       addr;
    group_noc_pkg::op_e       op;
    logic [7:0]               stall;  // Sinks held off, [3:0] tiles, [7:4] North..West
  } stim_t;

  stim_t stim_tab [NUM_STIM] = '{
    '{1'b0, 3'd0, 1'b0, OWN,           12'h005, RD, 8'h00},  // Local delivery
    '{1'b0, 3'd2, 1'b0, OWN,           12'hC10, WR, 8'h00},
    '{1'b0, 3'd3, 1'b0, OWN,           12'h7A3, RD, 8'h00},
    '{1'b0, 3'd0, 1'b0, '{2'd2, 2'd0}, 12'h123, WR, 8'h00},  // East, x first
    '{1'b0, 3'd1, 1'b0, '{2'd0, 2'd3}, 12'h456, RD, 8'h00},  // West
    '{1'b0, 3'd2, 1'b0, '{2'd1, 2'd3}, 12'h789, WR, 8'h00},  // North
    '{1'b0, 3'd3, 1'b0, '{2'd1, 2'd0}, 12'hABC, RD, 8'h00},  // South
    '{1'b1, 3'd1, 1'b0, OWN,           12'h404, WR, 8'h00},  // From North to tile 1
    '{1'b1, 3'd4, 1'b0, OWN,           12'hFFF, RD, 8'h00},  // From West to tile 3
    '{1'b1, 3'd4, 1'b0, '{2'd3, 2'd1}, 12'h111, WR, 8'h00},  // Through to East
    '{1'b1, 3'd1, 1'b0, '{2'd1, 2'd1}, 12'h444, RD, 8'h00},  // Through to South
    '{1'b0, 3'd1, 1'b0, OWN,           12'h812, WR, 8'h04},  // Tile 2 stalled
    '{1'b0, 3'd1, 1'b0, OWN,           12'h813, WR, 8'h00},
    '{1'b0, 3'd1, 1'b0, OWN,           12'h814, RD, 8'h00},
    '{1'b0, 3'd0, 1'b1, OWN,           12'h400, WR, 8'h02},  // All tiles at once
    '{1'b0, 3'd1, 1'b1, OWN,           12'h401, WR, 8'h00},
    '{1'b0, 3'd2, 1'b1, OWN,           12'h402, RD, 8'h00},
    '{1'b0, 3'd3, 1'b0, OWN,           12'h403, WR, 8'h00}
  };

  logic                                       clk_i;
  logic                                       rst_n_i;
  group_noc_pkg::group_xy_t                   group_id_i;
  group_noc_pkg::tile_req_t  [`NUM_TILES-1:0] tile_req_i;
  logic                      [`NUM_TILES-1:0] tile_valid_i;
  logic                      [`NUM_TILES-1:0] tile_ready_o;
  group_noc_pkg::slave_req_t [`NUM_TILES-1:0] slave_req_o;
  logic                      [`NUM_TILES-1:0] slave_valid_o;
  logic                      [`NUM_TILES-1:0] slave_ready_i;
  group_noc_pkg::flit_t      [4:1]            mesh_flit_i;
  logic                      [4:1]            mesh_valid_i;
  logic                      [4:1]            mesh_ready_o;
  group_noc_pkg::flit_t      [4:1]            mesh_flit_o;
  logic                      [4:1]            mesh_valid_o;
  logic                      [4:1]            mesh_ready_i;

  // Next-cycle input values, applied on the falling edge
  logic                                      rst_n_q;
  group_noc_pkg::tile_req_t [`NUM_TILES-1:0] tile_req_q;
  logic                     [`NUM_TILES-1:0] tile_valid_q;
  group_noc_pkg::flit_t     [4:1]            mesh_flit_q;
  logic                     [4:1]            mesh_valid_q;
  int                                        stall_left [8];
  int                                        accept_left;
  group_noc_pkg::flit_t                      pend_flit [$];  // Issued, not yet delivered
  int                                        pend_sink [$];
  logic [31:0]                               rng_state;

  group_noc_top uut (
    .clk_i         (clk_i        ),
    .rst_n_i       (rst_n_i      ),
    .group_id_i    (group_id_i   ),
    .tile_req_i    (tile_req_i   ),
    .tile_valid_i  (tile_valid_i ),
    .tile_ready_o  (tile_ready_o ),
    .slave_req_o   (slave_req_o  ),
    .slave_valid_o (slave_valid_o),
    .slave_ready_i (slave_ready_i),
    .mesh_flit_i   (mesh_flit_i  ),
    .mesh_valid_i  (mesh_valid_i ),
    .mesh_ready_o  (mesh_ready_o ),
    .mesh_flit_o   (mesh_flit_o  ),
    .mesh_valid_o  (mesh_valid_o ),
    .mesh_ready_i  (mesh_ready_i )
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Sinks 0..3 are tiles, 4..7 the mesh outputs North..West
  function automatic int expected_sink(input group_noc_pkg::flit_t f);
    if (f.dst_group.x > OWN.x) return 3 + int'(group_noc_pkg::DIR_EAST);
    if (f.dst_group.x < OWN.x) return 3 + int'(group_noc_pkg::DIR_WEST);
    if (f.dst_group.y > OWN.y) return 3 + int'(group_noc_pkg::DIR_NORTH);
    if (f.dst_group.y < OWN.y) return 3 + int'(group_noc_pkg::DIR_SOUTH);
    return int'(f.addr[`ADDR_W-1 -: `TILE_ID_W]);
  endfunction

  function automatic group_noc_pkg::slave_req_t to_slave(input group_noc_pkg::flit_t f);
    group_noc_pkg::slave_req_t r;
    r.op        = f.op;
    r.be        = f.be;
    r.addr      = f.addr[`TILE_ADDR_W-1:0];  // Tile bits stripped
    r.data      = f.data;
    r.src_group = f.src_group;
    r.src_tile  = f.src_tile;
    return r;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  // Oldest pending entry of the same source and sink must match
  task automatic match_arrival(input int sink, input group_noc_pkg::group_xy_t sg,
                               input logic [`TILE_ID_W-1:0] st, input logic [FLIT_W-1:0] obs);
    int                idx;
    logic [FLIT_W-1:0] expv;
    idx = -1;
    for (int i = 0; i < pend_flit.size(); i++) begin
      if (idx < 0 && pend_sink[i] == sink && pend_flit[i].src_group == sg &&
          pend_flit[i].src_tile == st) idx = i;
    end
    assert (idx >= 0) else
      abort_run($sformatf("ERROR %0t: unexpected transfer at sink %0d: %h", $time, sink, obs));
    if (sink < `NUM_TILES) expv = FLIT_W'(to_slave(pend_flit[idx]));
    else expv = pend_flit[idx];
    assert (obs == expv) else
      abort_run($sformatf("ERROR %0t: sink %0d got %h, expected %h", $time, sink, obs, expv));
    pend_flit.delete(idx);
    pend_sink.delete(idx);
  endtask

  // One cycle: drive on the falling edge, sample once settled
  task automatic tick();
    logic rdy;
    @(negedge clk_i);
    rst_n_i      = rst_n_q;
    tile_req_i   = tile_req_q;
    tile_valid_i = tile_valid_q;
    mesh_flit_i  = mesh_flit_q;
    mesh_valid_i = mesh_valid_q;
    for (int s = 0; s < 8; s++) begin
      rdy = (stall_left[s] == 0);
      if (!rdy) stall_left[s]--;
      if (s < 4) slave_ready_i[s] = rdy;
      else mesh_ready_i[s-3] = rdy;
    end
    #2;
    assert ($onehot0(slave_valid_o)) else
      abort_run($sformatf("ERROR %0t: several slave valids %b", $time, slave_valid_o));
    for (int t = 0; t < `NUM_TILES; t++) begin
      if (slave_valid_o[t] && slave_ready_i[t])
        match_arrival(t, slave_req_o[t].src_group, slave_req_o[t].src_tile,
                      FLIT_W'(slave_req_o[t]));
      if (tile_valid_i[t] && tile_ready_o[t]) begin
        tile_valid_q[t] = 1'b0;
        accept_left--;
      end
    end
    for (int d = 1; d <= 4; d++) begin
      if (mesh_valid_o[d] && mesh_ready_i[d])
        match_arrival(3 + d, mesh_flit_o[d].src_group, mesh_flit_o[d].src_tile, mesh_flit_o[d]);
      if (mesh_valid_i[d] && mesh_ready_o[d]) begin
        mesh_valid_q[d] = 1'b0;
        accept_left--;
      end
    end
  endtask

  task automatic issue_batch(input int first, input int last);
    stim_t                e;
    group_noc_pkg::flit_t f;
    int                   n;
    for (int k = first; k <= last; k++) begin
      e = stim_tab[k];
      if (e.mesh) begin
        f.src_group.x = 2'(e.src - 3'd1);  // Some foreign group per port
        f.src_group.y = 2'd0;
      end else begin
        f.src_group = OWN;
      end
      f.src_tile  = e.src[1:0];
      f.dst_group = e.dst;
      f.addr      = e.addr;
      f.op        = e.op;
      f.be        = 4'(next_rand());
      f.data      = next_rand();
      pend_flit.push_back(f);
      pend_sink.push_back(expected_sink(f));
      for (int s = 0; s < 8; s++) if (e.stall[s]) stall_left[s] = STALL_CYC;
      if (e.mesh) begin
        mesh_flit_q[e.src]  = f;
        mesh_valid_q[e.src] = 1'b1;
      end else begin
        tile_req_q[e.src[1:0]] = '{op: f.op, be: f.be, addr: f.addr, data: f.data,
                                   dst_group: f.dst_group};
        tile_valid_q[e.src[1:0]] = 1'b1;
      end
      accept_left++;
    end
    n = 0;
    while (accept_left > 0) begin
      assert (n < TIMEOUT) else abort_run("Timeout: a request was never accepted");
      tick();
      n++;
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    int i;
    int j;
    int n;
    rst_n_i       = 1'b0;
    group_id_i    = OWN;
    tile_req_i    = '0;
    tile_valid_i  = '0;
    slave_ready_i = '1;
    mesh_flit_i   = '0;
    mesh_valid_i  = '0;
    mesh_ready_i  = '1;
    rst_n_q       = 1'b0;
    tile_req_q    = '0;
    tile_valid_q  = '0;
    mesh_flit_q   = '0;
    mesh_valid_q  = '0;
    accept_left   = 0;
    rng_state     = 32'd43559;
    for (int s = 0; s < 8; s++) stall_left[s] = 0;
    repeat (8) tick();
    assert (tile_ready_o == '0 && mesh_ready_o == '0 && slave_valid_o == '0 &&
            mesh_valid_o == '0) else
      abort_run($sformatf("ERROR %0t: outputs active during reset", $time));
    rst_n_q = 1'b1;
    i = 0;
    while (i < NUM_STIM) begin
      j = i;
      while (j < NUM_STIM - 1 && stim_tab[j].sync) j++;
      issue_batch(i, j);
      i = j + 1;
    end
    n = 0;
    while (pend_flit.size() > 0) begin
      assert (n < TIMEOUT) else abort_run("Timeout: some requests were never delivered");
      tick();
      n++;
    end
    repeat (10) tick();  // Duplicates would arrive here
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+include
src/group_noc_pkg.sv
src/flit_fifo.sv
src/tcdm_flit_packer.sv
src/xy_router.sv
src/tile_req_demux.sv
src/group_noc_top.sv
sim/tb_group_noc.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --assert -Wno-fatal --top-module tb_group_noc \
  -f all.f -o sim_group_noc

./obj_dir/sim_group_noc | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
  exit 0
else
  exit 1
fi
